/* logic/mem_sys_pkg.sv */
// memory system shared definitions
// bus commands, miss-handling states and bus widths
`default_nettype none

package mem_sys_pkg;

    ////////////////////////////////////////////////////////////
    // bus geometry
    ////////////////////////////////////////////////////////////

    // byte address
    localparam int ADDR_WIDTH = 32;
    // one doubleword per line and per memory beat
    localparam int LINE_WIDTH = 64;
    // zero tag means no tag
    localparam int MEM_TAG_WIDTH = 4;
    // byte offset inside a line
    localparam int LINE_OFFSET_BITS = 3;

    ////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } bus_command_e;

    // miss handling, shared by both caches
    typedef enum logic [1:0] {
        IDLE      = 2'h0,
        REQUEST   = 2'h1,
        WAIT_DATA = 2'h2
    } cache_state_e;

endpackage

`default_nettype wire

/* logic/mem_port_if.sv */
// one requester's side of the shared memory port
// request goes toward the arbiter, response tag and load data come back
`default_nettype none

interface mem_port_if import mem_sys_pkg::*; ();

    // request, held by the cache until a nonzero response
    bus_command_e             command;
    logic [ADDR_WIDTH-1:0]    addr;
    logic [LINE_WIDTH-1:0]    wdata;

    // same-cycle accept tag, gated by the arbiter
    logic [MEM_TAG_WIDTH-1:0] response;
    // load return, broadcast to every requester
    logic [LINE_WIDTH-1:0]    rdata;
    logic [MEM_TAG_WIDTH-1:0] tag;

    modport requester (output command, addr, wdata, input response, rdata, tag);

    modport arbiter (input command, addr, wdata, output response, rdata, tag);

endinterface

`default_nettype wire

/* logic/inst_cache.sv */
// direct-mapped read-only instruction cache
// zero-latency hits, one outstanding line fill at a time
`default_nettype none

module inst_cache import mem_sys_pkg::*; #(
    parameter int ICACHE_LINES = 32
) (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire logic [ADDR_WIDTH-1:0] fetch_addr,
    output logic      [LINE_WIDTH-1:0] fetch_data,
    output logic                       fetch_valid,
    mem_port_if.requester              mem_port
);

    localparam int IDX_BITS       = $clog2(ICACHE_LINES);
    localparam int LINE_ADDR_BITS = ADDR_WIDTH - LINE_OFFSET_BITS;
    localparam int TAG_BITS       = LINE_ADDR_BITS - IDX_BITS;

    // line storage
    logic [LINE_WIDTH-1:0]    line_data [ICACHE_LINES];
    logic [TAG_BITS-1:0]      line_tag [ICACHE_LINES];
    logic [ICACHE_LINES-1:0]  line_valid;

    cache_state_e             state;
    cache_state_e             state_next;
    // line address and memory tag of the miss in flight
    logic [LINE_ADDR_BITS-1:0] req_line;
    logic [MEM_TAG_WIDTH-1:0] pending_tag;

    logic [IDX_BITS-1:0]      fetch_index;
    logic [TAG_BITS-1:0]      fetch_tag;
    logic [IDX_BITS-1:0]      req_index;
    logic                     hit;
    logic                     accepted;
    logic                     fill;

    assign fetch_index = fetch_addr[LINE_OFFSET_BITS +: IDX_BITS];
    assign fetch_tag   = fetch_addr[ADDR_WIDTH-1 -: TAG_BITS];
    assign req_index   = req_line[IDX_BITS-1:0];

    // lookup, valid in any state
    assign hit         = line_valid[fetch_index] && (line_tag[fetch_index] == fetch_tag);
    assign fetch_data  = line_data[fetch_index];
    assign fetch_valid = hit;

    assign accepted = (state == REQUEST) && (mem_port.response != '0);
    assign fill     = (state == WAIT_DATA) && (mem_port.tag == pending_tag);

    // load request only while in REQUEST
    assign mem_port.command = (state == REQUEST) ? BUS_LOAD : BUS_NONE;
    assign mem_port.addr    = {req_line, {LINE_OFFSET_BITS{1'b0}}};
    assign mem_port.wdata   = '0;

    ////////////////////////////////////////////////////////////
    // miss FSM
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            IDLE:      if (!hit) state_next = REQUEST;
            REQUEST:   if (accepted) state_next = WAIT_DATA;
            WAIT_DATA: if (fill) state_next = IDLE;
            default:   state_next = IDLE;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= IDLE;
            line_valid <= '0;
        end else begin
            state <= state_next;
            if (fill) line_valid[req_index] <= 1'b1;
        end
    end

    // miss capture and line fill
    always_ff @(posedge clock) begin
        // a later change of fetch_addr does not disturb the fill
        if (state == IDLE && !hit) req_line <= fetch_addr[ADDR_WIDTH-1:LINE_OFFSET_BITS];
        if (accepted) pending_tag <= mem_port.response;
        if (fill) begin
            line_data[req_index] <= mem_port.rdata;
            line_tag[req_index]  <= req_line[LINE_ADDR_BITS-1 -: TAG_BITS];
        end
    end

endmodule

`default_nettype wire

/* logic/data_cache.sv */
// direct-mapped write-through data cache, no write allocate
// doubleword loads fill on miss, every store goes out to memory
`default_nettype none

module data_cache import mem_sys_pkg::*; #(
    parameter int DCACHE_LINES = 16
) (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire bus_command_e          data_command,
    input  wire logic [ADDR_WIDTH-1:0] data_addr,
    input  wire logic [LINE_WIDTH-1:0] data_wdata,
    output logic      [LINE_WIDTH-1:0] data_rdata,
    output logic                       data_done,
    mem_port_if.requester              mem_port
);

    localparam int IDX_BITS       = $clog2(DCACHE_LINES);
    localparam int LINE_ADDR_BITS = ADDR_WIDTH - LINE_OFFSET_BITS;
    localparam int TAG_BITS       = LINE_ADDR_BITS - IDX_BITS;

    // line storage
    logic [LINE_WIDTH-1:0]    line_data [DCACHE_LINES];
    logic [TAG_BITS-1:0]      line_tag [DCACHE_LINES];
    logic [DCACHE_LINES-1:0]  line_valid;

    cache_state_e             state;
    cache_state_e             state_next;
    // the request being sent to memory
    bus_command_e             req_command;
    logic [LINE_ADDR_BITS-1:0] req_line;
    logic [MEM_TAG_WIDTH-1:0] pending_tag;

    logic [IDX_BITS-1:0]      data_index;
    logic [TAG_BITS-1:0]      data_tag;
    logic [IDX_BITS-1:0]      req_index;
    logic [TAG_BITS-1:0]      req_tag;
    logic                     is_load;
    logic                     is_store;
    logic                     hit;
    logic                     req_hit;
    logic                     accepted;
    logic                     store_accepted;
    logic                     fill;

    assign data_index = data_addr[LINE_OFFSET_BITS +: IDX_BITS];
    assign data_tag   = data_addr[ADDR_WIDTH-1 -: TAG_BITS];
    assign req_index  = req_line[IDX_BITS-1:0];
    assign req_tag    = req_line[LINE_ADDR_BITS-1 -: TAG_BITS];

    assign is_load  = (data_command == BUS_LOAD);
    assign is_store = (data_command == BUS_STORE);

    // lookup for the incoming request
    assign hit        = line_valid[data_index] && (line_tag[data_index] == data_tag);
    assign data_rdata = line_data[data_index];
    // lookup for the registered request, used by the store update
    assign req_hit    = line_valid[req_index] && (line_tag[req_index] == req_tag);

    assign accepted       = (state == REQUEST) && (mem_port.response != '0);
    assign store_accepted = accepted && (req_command == BUS_STORE);
    assign fill           = (state == WAIT_DATA) && (mem_port.tag == pending_tag);

    // load hit at once, store on acceptance
    assign data_done = ((state == IDLE) && is_load && hit) || store_accepted;

    // store data comes straight from the held request
    assign mem_port.command = (state == REQUEST) ? req_command : BUS_NONE;
    assign mem_port.addr    = {req_line, {LINE_OFFSET_BITS{1'b0}}};
    assign mem_port.wdata   = data_wdata;

    ////////////////////////////////////////////////////////////
    // request FSM
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (is_store || (is_load && !hit)) state_next = REQUEST;
            end
            REQUEST: begin
                // a store is finished once memory takes it
                if (store_accepted) state_next = IDLE;
                else if (accepted) state_next = WAIT_DATA;
            end
            WAIT_DATA: if (fill) state_next = IDLE;
            default:   state_next = IDLE;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= IDLE;
            line_valid <= '0;
        end else begin
            state <= state_next;
            if (fill) line_valid[req_index] <= 1'b1;
        end
    end

    // request capture, line fill and store update
    always_ff @(posedge clock) begin
        if (state == IDLE && state_next == REQUEST) begin
            req_command <= data_command;
            req_line    <= data_addr[ADDR_WIDTH-1:LINE_OFFSET_BITS];
        end
        if (accepted) pending_tag <= mem_port.response;
        if (fill) begin
            line_data[req_index] <= mem_port.rdata;
            line_tag[req_index]  <= req_tag;
        end
        // keep a resident line in step with memory
        if (store_accepted && req_hit) line_data[req_index] <= data_wdata;
    end

endmodule

`default_nettype wire

/* logic/mem_arbiter.sv */
// shares one tagged memory port between instruction and data caches
// registered ownership, the data cache wins
`default_nettype none

module mem_arbiter import mem_sys_pkg::*; (
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire logic [MEM_TAG_WIDTH-1:0] mem_response,
    input  wire logic [LINE_WIDTH-1:0]    mem_rdata,
    input  wire logic [MEM_TAG_WIDTH-1:0] mem_tag,
    output bus_command_e                  mem_command,
    output logic      [ADDR_WIDTH-1:0]    mem_addr,
    output logic      [LINE_WIDTH-1:0]    mem_wdata,
    mem_port_if.arbiter                   i_port,
    mem_port_if.arbiter                   d_port
);

    // data cache asked last cycle, and the cycle before
    logic data_owner;
    logic prev_data_owner;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            data_owner      <= 1'b0;
            prev_data_owner <= 1'b0;
        end else begin
            data_owner      <= (d_port.command != BUS_NONE);
            prev_data_owner <= data_owner;
        end
    end

    ////////////////////////////////////////////////////////////
    // request mux
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (data_owner) begin
            mem_command = d_port.command;
            mem_addr    = d_port.addr;
            mem_wdata   = d_port.wdata;
        end else begin
            mem_command = i_port.command;
            mem_addr    = i_port.addr;
            mem_wdata   = i_port.wdata;
        end
    end

    // response only once ownership has settled
    // on a switch nobody sees the tag and the owner retries
    assign d_port.response = (data_owner && prev_data_owner) ? mem_response : '0;
    assign i_port.response = (!data_owner && !prev_data_owner) ? mem_response : '0;

    // each cache matches its own pending tag
    assign i_port.rdata = mem_rdata;
    assign i_port.tag   = mem_tag;
    assign d_port.rdata = mem_rdata;
    assign d_port.tag   = mem_tag;

endmodule

`default_nettype wire

/* logic/mem_system.sv */
// memory system top level
// instruction and data caches sharing one tagged memory port
`default_nettype none

module mem_system import mem_sys_pkg::*; #(
    parameter int ICACHE_LINES = 32,
    parameter int DCACHE_LINES = 16
) (
    input  wire logic                     clock,
    input  wire logic                     reset,
    // fetch side
    input  wire logic [ADDR_WIDTH-1:0]    fetch_addr,
    output logic      [LINE_WIDTH-1:0]    fetch_data,
    output logic                          fetch_valid,
    // data side, held until data_done
    input  wire bus_command_e             data_command,
    input  wire logic [ADDR_WIDTH-1:0]    data_addr,
    input  wire logic [LINE_WIDTH-1:0]    data_wdata,
    output logic      [LINE_WIDTH-1:0]    data_rdata,
    output logic                          data_done,
    // main memory
    output bus_command_e                  mem_command,
    output logic      [ADDR_WIDTH-1:0]    mem_addr,
    output logic      [LINE_WIDTH-1:0]    mem_wdata,
    input  wire logic [MEM_TAG_WIDTH-1:0] mem_response,
    input  wire logic [LINE_WIDTH-1:0]    mem_rdata,
    input  wire logic [MEM_TAG_WIDTH-1:0] mem_tag
);

    // per-cache ports into the arbiter
    mem_port_if i_port ();
    mem_port_if d_port ();

    inst_cache #(
        .ICACHE_LINES(ICACHE_LINES)
    ) u_inst_cache (
        .clock(clock),
        .reset(reset),
        .fetch_addr(fetch_addr),
        .fetch_data(fetch_data),
        .fetch_valid(fetch_valid),
        .mem_port(i_port)
    );

    data_cache #(
        .DCACHE_LINES(DCACHE_LINES)
    ) u_data_cache (
        .clock(clock),
        .reset(reset),
        .data_command(data_command),
        .data_addr(data_addr),
        .data_wdata(data_wdata),
        .data_rdata(data_rdata),
        .data_done(data_done),
        .mem_port(d_port)
    );

    mem_arbiter u_mem_arbiter (
        .clock(clock),
        .reset(reset),
        .mem_response(mem_response),
        .mem_rdata(mem_rdata),
        .mem_tag(mem_tag),
        .mem_command(mem_command),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .i_port(i_port),
        .d_port(d_port)
    );

endmodule

`default_nettype wire

/* test/main_memory_model.sv */
// tagged main memory for the testbench
// same-cycle accept tag, load data a fixed number of cycles later
`default_nettype none

module main_memory_model import mem_sys_pkg::*; #(
    parameter int          MEM_LINES    = 64,
    parameter int          LOAD_LATENCY = 4,
    parameter logic [31:0] REJECT_SEED  = 32'hd33c
) (
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire bus_command_e             command,
    input  wire logic [ADDR_WIDTH-1:0]    addr,
    input  wire logic [LINE_WIDTH-1:0]    wdata,
    output logic      [MEM_TAG_WIDTH-1:0] response,
    output logic      [LINE_WIDTH-1:0]    rdata,
    output logic      [MEM_TAG_WIDTH-1:0] tag
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int INDEX_BITS = $clog2(MEM_LINES);

    logic [LINE_WIDTH-1:0]    lines [MEM_LINES];
    logic [MEM_TAG_WIDTH-1:0] next_tag;
    // load return pipeline, zero tag marks an empty slot
    logic [MEM_TAG_WIDTH-1:0] pipe_tag [LOAD_LATENCY];
    logic [LINE_WIDTH-1:0]    pipe_data [LOAD_LATENCY];
    logic [31:0]              reject_lfsr;
    logic [INDEX_BITS-1:0]    index;
    logic                     reject;
    logic                     accept;

    // fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // byte address of the line, doubled up and scrambled
    function automatic logic [LINE_WIDTH-1:0] line_pattern(input int line);
        logic [31:0] base;
        base = 32'(line) << LINE_OFFSET_BITS;
        return {base, base} ^ 64'ha5a5_0000_5a5a_ffff;
    endfunction

    // two fresh bits per cycle, reject when both set
    assign reject   = reject_lfsr[0] & reject_lfsr[1];
    assign index    = addr[LINE_OFFSET_BITS +: INDEX_BITS];
    assign accept   = (command != BUS_NONE) && !reject;
    assign response = accept ? next_tag : '0;
    assign tag      = pipe_tag[LOAD_LATENCY-1];
    assign rdata    = pipe_data[LOAD_LATENCY-1];

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            reject_lfsr <= REJECT_SEED;
            next_tag    <= 4'd1;
            for (int i = 0; i < MEM_LINES; i++) lines[i] <= line_pattern(i);
            for (int s = 0; s < LOAD_LATENCY; s++) begin
                pipe_tag[s]  <= '0;
                pipe_data[s] <= '0;
            end
        end else begin
            reject_lfsr <= lfsr_next(lfsr_next(reject_lfsr));
            if (accept) begin
                // tags run 1..15, zero is never handed out
                next_tag <= (next_tag == '1) ? 4'd1 : next_tag + 4'd1;
                if (command == BUS_STORE) lines[index] <= wdata;
            end
            pipe_tag[0]  <= (accept && command == BUS_LOAD) ? next_tag : '0;
            pipe_data[0] <= lines[index];
            for (int s = 1; s < LOAD_LATENCY; s++) begin
                pipe_tag[s]  <= pipe_tag[s-1];
                pipe_data[s] <= pipe_data[s-1];
            end
        end
    end

endmodule

`default_nettype wire

/* test/mem_system_tb.sv */
// testbench for the memory system
// random fetches, loads and stores checked against a shadow memory
`default_nettype none

module mem_system_tb import mem_sys_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ICACHE_LINES = 32;
    localparam int DCACHE_LINES = 16;
    localparam int MEM_LINES    = 64;
    // about 150 accesses of well under 100 cycles each even with rejects
    localparam int TIMEOUT_CYCLES = 20000;
    // same icache index with another tag
    localparam logic [5:0] EVICT_FLIP = 6'(ICACHE_LINES);

    logic                     clock = 1'b0;
    logic                     reset;
    logic [ADDR_WIDTH-1:0]    fetch_addr;
    logic [LINE_WIDTH-1:0]    fetch_data;
    logic                     fetch_valid;
    bus_command_e             data_command;
    logic [ADDR_WIDTH-1:0]    data_addr;
    logic [LINE_WIDTH-1:0]    data_wdata;
    logic [LINE_WIDTH-1:0]    data_rdata;
    logic                     data_done;
    bus_command_e             mem_command;
    logic [ADDR_WIDTH-1:0]    mem_addr;
    logic [LINE_WIDTH-1:0]    mem_wdata;
    logic [MEM_TAG_WIDTH-1:0] mem_response;
    logic [LINE_WIDTH-1:0]    mem_rdata;
    logic [MEM_TAG_WIDTH-1:0] mem_tag;

    // expected memory content
    logic [LINE_WIDTH-1:0]    shadow [MEM_LINES];
    logic [31:0]              lfsr_state = 32'hd33c;
    int                       cycle_count = 0;
    int                       reject_count = 0;

    mem_system #(
        .ICACHE_LINES(ICACHE_LINES),
        .DCACHE_LINES(DCACHE_LINES)
    ) u_dut (.*);

    main_memory_model #(
        .MEM_LINES(MEM_LINES)
    ) u_mem (
        .clock(clock),
        .reset(reset),
        .command(mem_command),
        .addr(mem_addr),
        .wdata(mem_wdata),
        .response(mem_response),
        .rdata(mem_rdata),
        .tag(mem_tag)
    );

    always #5 clock = ~clock;

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] line_addr(input logic [5:0] line);
        logic [ADDR_WIDTH-1:0] addr;
        addr = '0;
        addr[LINE_OFFSET_BITS +: 6] = line;
        return addr;
    endfunction

    // reset content is the line byte address doubled and xor-ed
    function automatic logic [LINE_WIDTH-1:0] line_pattern(input logic [5:0] line);
        return {line_addr(line), line_addr(line)} ^ 64'ha5a5_0000_5a5a_ffff;
    endfunction

    // one LFSR step per bit taken
    task automatic random_bits(input int count, output logic [63:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[62:0], lfsr_state[0]};
        end
    endtask

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected)
            else fail_run($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
    endtask

    // present a line and wait for fetch_valid
    task automatic fetch_line(input logic [5:0] line, input logic check, input string name);
        fetch_addr = line_addr(line);
        @(negedge clock);
        while (!fetch_valid) @(negedge clock);
        if (check) check_value(name, shadow[line], fetch_data);
        @(posedge clock);
        #1;
    endtask

    // command held until data_done and then dropped
    task automatic data_access(input bus_command_e command, input logic [5:0] line,
                               input logic [63:0] wdata, output logic [63:0] rdata);
        data_command = command;
        data_addr    = line_addr(line);
        data_wdata   = wdata;
        @(negedge clock);
        while (!data_done) @(negedge clock);
        rdata = data_rdata;
        @(posedge clock);
        #1;
        data_command = BUS_NONE;
    endtask

    ////////////////////////////////////////////////////////////
    // watchdogs
    ////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        if (cycle_count == TIMEOUT_CYCLES) fail_run("timeout, the tests did not finish");
        else cycle_count <= cycle_count + 1;
    end

    // memory turned a request away
    always @(negedge clock) begin
        if (!reset && mem_command != BUS_NONE && mem_response == '0)
            reject_count <= reject_count + 1;
    end

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    initial begin
        logic [63:0] value;
        logic [63:0] rdata;
        logic [5:0]  line;
        logic [5:0]  other;
        logic        fetch_seen;
        logic        load_seen;

        // a load already waiting during reset
        reset        = 1'b1;
        fetch_addr   = '0;
        data_command = BUS_LOAD;
        data_addr    = '0;
        data_wdata   = '0;
        for (int i = 0; i < MEM_LINES; i++) shadow[i] = line_pattern(6'(i));

        // outputs quiet while reset is held
        repeat (16) begin
            @(negedge clock);
            assert (!fetch_valid && !data_done && mem_command == BUS_NONE)
                else fail_run("outputs active while reset is high");
        end
        @(posedge clock);
        #1;
        reset        = 1'b0;
        data_command = BUS_NONE;

        // fetches where the same line again must hit at once
        for (int n = 0; n < 24; n++) begin
            random_bits(6, value);
            line = value[5:0];
            fetch_line(line, 1'b1, "fetch");
            fetch_addr = line_addr(line);
            @(negedge clock);
            assert (fetch_valid) else fail_run("repeated fetch did not hit at once");
            assert (!(mem_command == BUS_LOAD && mem_addr == line_addr(line)))
                else fail_run("repeated fetch went out to memory");
            check_value("fetch_repeat", shadow[line], fetch_data);
            @(posedge clock);
            #1;
        end

        // data loads
        for (int n = 0; n < 24; n++) begin
            random_bits(6, value);
            line = value[5:0];
            data_access(BUS_LOAD, line, '0, rdata);
            check_value("data_load", shadow[line], rdata);
        end

        // store and load back and fetch after evicting the icache line
        for (int n = 0; n < 12; n++) begin
            random_bits(6, value);
            line = value[5:0];
            random_bits(64, value);
            data_access(BUS_STORE, line, value, rdata);
            shadow[line] = value;
            data_access(BUS_LOAD, line, '0, rdata);
            check_value("store_load", shadow[line], rdata);
            fetch_line(line ^ EVICT_FLIP, 1'b0, "evict");
            fetch_line(line, 1'b1, "store_fetch");
        end

        // fetch miss and data load started together
        for (int n = 0; n < 16; n++) begin
            random_bits(6, value);
            line = value[5:0];
            random_bits(6, value);
            other = value[5:0];
            fetch_line(line ^ EVICT_FLIP, 1'b0, "evict");
            fetch_addr   = line_addr(line);
            data_command = BUS_LOAD;
            data_addr    = line_addr(other);
            fetch_seen   = 1'b0;
            load_seen    = 1'b0;
            while (!(fetch_seen && load_seen)) begin
                @(negedge clock);
                if (!fetch_seen && fetch_valid) begin
                    check_value("pair_fetch", shadow[line], fetch_data);
                    fetch_seen = 1'b1;
                end
                if (!load_seen && data_done) begin
                    check_value("pair_load", shadow[other], data_rdata);
                    load_seen = 1'b1;
                end
                @(posedge clock);
                #1;
                if (load_seen) data_command = BUS_NONE;
            end
        end

        if (reject_count > 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            fail_run("memory never rejected a request");
        end
    end

endmodule

`default_nettype wire

/* mem_system.f */
logic/mem_sys_pkg.sv
logic/mem_port_if.sv
logic/inst_cache.sv
logic/data_cache.sv
logic/mem_arbiter.sv
logic/mem_system.sv
test/main_memory_model.sv
test/mem_system_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the mem_system testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=mem_system_tb
OBJ_DIR=obj_dir

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found"
    exit 1
fi

if ! verilator --binary --timing --assert -j 0 \
        -f mem_system.f --top-module "$TOP" --Mdir "$OBJ_DIR"; then
    echo "build failed"
    exit 1
fi

output=$("./$OBJ_DIR/V$TOP" 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation completed successfully"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
